// File: hdl/pmp_checker.sv
// ==================
// Registered access check, result one cycle after the request.
// Lowest matching region wins, no match allows M and denies U
// ==================

`timescale 1ns/1ps

`include "pmp_consts.svh"

module pmp_checker
  import pmp_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              chk_valid_i,
  input  logic [31:0]                       chk_addr_i,
  input  pmp_acc_e                          chk_type_i,
  input  pmp_priv_e                         chk_priv_i,
  input  pmp_cfg_t [`PMP_NUM_REGIONS-1:0]   cfg_i,
  input  logic [`PMP_NUM_REGIONS-1:0][31:0] addr_i,
  output logic                              chk_valid_o,
  output logic                              chk_allow_o
);

  logic [`PMP_NUM_REGIONS-1:0]       match;
  logic [`PMP_NUM_REGIONS-1:0][31:0] addr_below;
  logic                              allow_d;

  // Region 0 has zero as its TOR lower bound
  assign addr_below = {addr_i[`PMP_NUM_REGIONS-2:0], 32'h0};

  for (genvar g = 0; g < `PMP_NUM_REGIONS; g++) begin : gen_match
    pmp_region_match i_pmp_region_match (
      .chk_addr_i   (chk_addr_i),
      .mode_i       (cfg_i[g].mode),
      .addr_i       (addr_i[g]),
      .addr_below_i (addr_below[g]),
      .match_o      (match[g])
    );
  end

  always_comb begin
    logic found;
    logic perm;
    found   = 1'b0;
    perm    = 1'b0;
    allow_d = (chk_priv_i == PRIV_M);
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      if (match[i] && !found) begin
        found = 1'b1;
        case (chk_type_i)
          ACC_READ:  perm = cfg_i[i].read;
          ACC_WRITE: perm = cfg_i[i].write;
          ACC_EXEC:  perm = cfg_i[i].exec;
          default:   perm = 1'b0;
        endcase
        // Lock makes the permissions binding for M-mode too
        if ((chk_priv_i != PRIV_M) || cfg_i[i].lock) begin
          allow_d = perm;
        end else begin
          allow_d = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      chk_valid_o <= 1'b0;
      chk_allow_o <= 1'b0;
    end else begin
      chk_valid_o <= chk_valid_i;
      chk_allow_o <= chk_valid_i && allow_d;
    end
  end

endmodule

// File: hdl/pmp_consts.svh
// ==================
// PMP build constants. The region count must be a multiple of four
// and the granularity G must stay within 0 to 29
// ==================

`ifndef PMP_CONSTS_SVH
`define PMP_CONSTS_SVH

// Region count and minimum region size of 2^(G+2) bytes
`define PMP_NUM_REGIONS 16
`define PMP_GRANULARITY 2
`define PMP_CFG_REGS (`PMP_NUM_REGIONS / 4)

// CSR numbers as seen on the Wishbone address
`define PMP_CSR_AW 12
`define PMP_CSR_PMPCFG0 12'h3A0
`define PMP_CSR_PMPADDR0 12'h3B0
`define PMP_CSR_MSECCFG 12'h747

// Rule locking bypass inside mseccfg
`define PMP_MSECCFG_RLB_BIT 2

`endif

// File: hdl/pmp_csr_file.sv
// ==================
// PMP register file on a Wishbone classic slave. Full word accesses
// only, every access is acked after one cycle. No MML support, RLB
// in mseccfg is a plain read/write bit
// ==================

`timescale 1ns/1ps

`include "pmp_consts.svh"

module pmp_csr_file
  import pmp_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 wb_cyc_i,
  input  logic                                 wb_stb_i,
  input  logic                                 wb_we_i,
  input  logic [`PMP_CSR_AW-1:0]               wb_adr_i,
  input  logic [31:0]                          wb_dat_i,
  output logic [31:0]                          wb_dat_o,
  output logic                                 wb_ack_o,
  output pmp_cfg_t [`PMP_NUM_REGIONS-1:0]      cfg_o,
  output logic [`PMP_NUM_REGIONS-1:0][31:0]    addr_o,
  output logic                                 rlb_o
);

  pmp_cfg_t [`PMP_NUM_REGIONS-1:0]   cfg_q;
  pmp_cfg_t [`PMP_NUM_REGIONS-1:0]   cfg_wdata;
  logic [`PMP_NUM_REGIONS-1:0][31:0] addr_q;
  logic [`PMP_NUM_REGIONS-1:0][31:0] addr_view;
  logic                              rlb_q;

  logic                              req;
  logic                              wr_en;
  logic [`PMP_CFG_REGS-1:0]          cfg_hit;
  logic [`PMP_NUM_REGIONS-1:0]       addr_hit;
  logic                              msec_hit;
  logic [`PMP_NUM_REGIONS-1:0]       tor_above;
  logic [`PMP_NUM_REGIONS-1:0]       addr_wr_block;
  logic [31:0]                       rdata_d;
  logic [31:0]                       rdata_q;

  // WARL rules for one config byte, applied in this order
  function automatic pmp_cfg_t legalize(pmp_cfg_t old_cfg, logic [7:0] wr, logic rlb);
    pmp_cfg_t res;
    res = pmp_cfg_t'(wr);
    // W without R is reserved
    if (res.write && !res.read) begin
      res.exec  = old_cfg.exec;
      res.write = old_cfg.write;
      res.read  = old_cfg.read;
    end
    if ((`PMP_GRANULARITY >= 1) && (res.mode == PMP_MODE_NA4)) begin
      res.mode = old_cfg.mode;
    end
    if (old_cfg.lock && !rlb) begin
      res = old_cfg;
    end
    res.zero = 2'b00;
    return res;
  endfunction

  // A new request is one that is not yet acked
  assign req   = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign wr_en = req && wb_we_i;

  for (genvar g = 0; g < `PMP_CFG_REGS; g++) begin : gen_cfg_hit
    assign cfg_hit[g] = (wb_adr_i == (`PMP_CSR_PMPCFG0 + 12'(g)));
  end

  assign msec_hit = (wb_adr_i == `PMP_CSR_MSECCFG);

  for (genvar g = 0; g < `PMP_NUM_REGIONS; g++) begin : gen_region
    assign addr_hit[g] = (wb_adr_i == (`PMP_CSR_PMPADDR0 + 12'(g)));

    // Locked TOR entry above guards this address as its lower bound
    if (g < `PMP_NUM_REGIONS - 1) begin : gen_tor_above
      assign tor_above[g] = cfg_q[g+1].lock && (cfg_q[g+1].mode == PMP_MODE_TOR);
    end else begin : gen_tor_top
      assign tor_above[g] = 1'b0;
    end

    assign addr_wr_block[g] = !rlb_q && (cfg_q[g].lock || tor_above[g]);
    assign cfg_wdata[g] = legalize(cfg_q[g], wb_dat_i[8*(g%4) +: 8], rlb_q);
  end

  // Granularity view, stored bits stay untouched
  always_comb begin
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      addr_view[i] = addr_q[i];
      for (int b = 0; b < `PMP_GRANULARITY; b++) begin
        if (cfg_q[i].mode inside {PMP_MODE_NA4, PMP_MODE_NAPOT}) begin
          if (b < `PMP_GRANULARITY - 1) begin
            addr_view[i][b] = 1'b1;
          end
        end else begin
          addr_view[i][b] = 1'b0;
        end
      end
    end
  end

  // Read mux, unmapped CSRs return zero
  always_comb begin
    rdata_d = '0;
    for (int r = 0; r < `PMP_CFG_REGS; r++) begin
      if (cfg_hit[r]) begin
        rdata_d = cfg_q[4*r+3 -: 4];
      end
    end
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      if (addr_hit[i]) begin
        rdata_d = addr_view[i];
      end
    end
    if (msec_hit) begin
      rdata_d[`PMP_MSECCFG_RLB_BIT] = rlb_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req) begin
      rdata_q <= rdata_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q  <= '0;
      addr_q <= '0;
      rlb_q  <= 1'b0;
    end else if (wr_en) begin
      for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
        if (cfg_hit[i/4]) begin
          cfg_q[i] <= cfg_wdata[i];
        end
        if (addr_hit[i] && !addr_wr_block[i]) begin
          addr_q[i] <= wb_dat_i;
        end
      end
      if (msec_hit) begin
        rlb_q <= wb_dat_i[`PMP_MSECCFG_RLB_BIT];
      end
    end
  end

  assign wb_dat_o = rdata_q;
  assign cfg_o    = cfg_q;
  assign addr_o   = addr_view;
  assign rlb_o    = rlb_q;

endmodule

// File: hdl/pmp_pkg.sv
// ==================
// Shared PMP types. Field order of pmp_cfg_t follows the
// pmpcfg byte layout of the privileged spec
// ==================

package pmp_pkg;

  // Address matching mode, the A field of pmpcfg
  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'b00,
    PMP_MODE_TOR   = 2'b01,
    PMP_MODE_NA4   = 2'b10,
    PMP_MODE_NAPOT = 2'b11
  } pmp_mode_e;

  // One pmpcfg byte, lock bit on top
  typedef struct packed {
    logic      lock;
    logic [1:0] zero;
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  // Only U and M are used by the checker
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } pmp_priv_e;

  typedef enum logic [1:0] {
    ACC_READ  = 2'b00,
    ACC_WRITE = 2'b01,
    ACC_EXEC  = 2'b10
  } pmp_acc_e;

endpackage

// File: hdl/pmp_region_match.sv
// ==================
// Address match of one PMP region, purely combinational.
// Register values are word addresses (byte address >> 2)
// ==================

`timescale 1ns/1ps

module pmp_region_match
  import pmp_pkg::*;
(
  input  logic [31:0] chk_addr_i,
  input  pmp_mode_e   mode_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] addr_below_i,
  output logic        match_o
);

  logic [31:0] word_addr;
  logic [31:0] napot_mask;
  logic        tor_match;
  logic        na4_match;
  logic        napot_match;

  // Compare in word units, the 34-bit byte space fits in 32 bits here
  assign word_addr = {2'b00, chk_addr_i[31:2]};

  // Bottom is inclusive, top is exclusive
  assign tor_match = (word_addr >= addr_below_i) && (word_addr < addr_i);

  assign na4_match = (word_addr == addr_i);

  // Trailing ones plus the first zero above them mark the ignored bits,
  // k trailing ones give a block of 2^(k+3) bytes
  assign napot_mask = addr_i ^ (addr_i + 32'd1);

  assign napot_match = ((word_addr ^ addr_i) & ~napot_mask) == '0;

  always_comb begin
    case (mode_i)
      PMP_MODE_TOR: begin
        match_o = tor_match;
      end
      PMP_MODE_NA4: begin
        match_o = na4_match;
      end
      PMP_MODE_NAPOT: begin
        match_o = napot_match;
      end
      default: begin
        // OFF never matches
        match_o = 1'b0;
      end
    endcase
  end

endmodule

// File: hdl/pmp_top.sv
// ==================
// PMP unit top. CSR port is M-mode only, checks are pipelined
// with one cycle latency and never stall
// ==================

`timescale 1ns/1ps

`include "pmp_consts.svh"

module pmp_top
  import pmp_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [`PMP_CSR_AW-1:0] wb_adr_i,
  input  logic [31:0]            wb_dat_i,
  output logic [31:0]            wb_dat_o,
  output logic                   wb_ack_o,
  input  logic                   chk_valid_i,
  input  logic [31:0]            chk_addr_i,
  input  pmp_acc_e               chk_type_i,
  input  pmp_priv_e              chk_priv_i,
  output logic                   chk_valid_o,
  output logic                   chk_allow_o
);

  pmp_cfg_t [`PMP_NUM_REGIONS-1:0]   cfg;
  logic [`PMP_NUM_REGIONS-1:0][31:0] addr;

  pmp_csr_file i_pmp_csr_file (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .cfg_o    (cfg),
    .addr_o   (addr),
    // Lock bypass only affects register writes, not the check
    .rlb_o    ()
  );

  pmp_checker i_pmp_checker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .chk_valid_i (chk_valid_i),
    .chk_addr_i  (chk_addr_i),
    .chk_type_i  (chk_type_i),
    .chk_priv_i  (chk_priv_i),
    .cfg_i       (cfg),
    .addr_i      (addr),
    .chk_valid_o (chk_valid_o),
    .chk_allow_o (chk_allow_o)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the PMP testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --timescale 1ns/1ps --top-module pmp_tb -f sim.f -o pmp_sim

# The exit status of the pipe is that of tee, the log decides the result
./obj_dir/pmp_sim | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"

// File: sim.f
+incdir+hdl
hdl/pmp_pkg.sv
hdl/pmp_region_match.sv
hdl/pmp_checker.sv
hdl/pmp_csr_file.sv
hdl/pmp_top.sv
test/pmp_tb.sv

// File: test/pmp_tb.sv
// ==================
// Self-checking testbench for the PMP unit. Stimulus and expected
// values are read from test/pmp_testdata.txt relative to the project root
// ==================

`timescale 1ns/1ps

`include "pmp_consts.svh"

module pmp_tb
  import pmp_pkg::*;
();

  localparam int max_lines = 128;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   wb_cyc_i;
  logic                   wb_stb_i;
  logic                   wb_we_i;
  logic [`PMP_CSR_AW-1:0] wb_adr_i;
  logic [31:0]            wb_dat_i;
  logic [31:0]            wb_dat_o;
  logic                   wb_ack_o;
  logic                   chk_valid_i;
  logic [31:0]            chk_addr_i;
  pmp_acc_e               chk_type_i;
  pmp_priv_e              chk_priv_i;
  logic                   chk_valid_o;
  logic                   chk_allow_o;

  // Per data line entries with op as the ASCII code of the line type
  logic [7:0]             op_mem    [max_lines];
  logic [`PMP_CSR_AW-1:0] csr_mem   [max_lines];
  logic [31:0]            dat_mem   [max_lines];
  logic [31:0]            addr_mem  [max_lines];
  logic [1:0]             type_mem  [max_lines];
  logic [1:0]             priv_mem  [max_lines];
  logic                   allow_mem [max_lines];
  int                     num_lines;
  int                     cycle_limit = 100;
  int                     cycle_count = 0;

  pmp_top i_pmp_top (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .chk_valid_i (chk_valid_i),
    .chk_addr_i  (chk_addr_i),
    .chk_type_i  (chk_type_i),
    .chk_priv_i  (chk_priv_i),
    .chk_valid_o (chk_valid_o),
    .chk_allow_o (chk_allow_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic stop_on_failure(input string reason);
    $display("%s", reason);
    $display("FAIL: see errors above");
    $fatal(1, "Test aborted");
  endtask

  task automatic compare_values(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
    if (actual !== expected) begin
      stop_on_failure($sformatf("Mismatch at %0t: %s, got %h, expected %h",
                                $time, what, actual, expected));
    end
  endtask

  // Watchdog sized from the number of data entries
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      stop_on_failure($sformatf("Timeout: the test did not finish within %0d clock cycles",
                                cycle_limit));
    end
  end

  task automatic load_testdata();
    int                     fd;
    int                     rc;
    logic [7:0]             tok;
    logic [8*160-1:0]       rest;
    logic [`PMP_CSR_AW-1:0] t_csr;
    logic [31:0]            t_dat;
    logic [31:0]            t_addr;
    logic [1:0]             t_type;
    logic [1:0]             t_priv;
    logic                   t_allow;
    num_lines = 0;
    rc = 0;
    fd = $fopen("test/pmp_testdata.txt", "r");
    if (fd == 0) begin
      stop_on_failure("Cannot open test/pmp_testdata.txt, run from the project root");
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok == "#") begin
        rc = $fgets(rest, fd);
      end else begin
        if (num_lines >= max_lines) begin
          stop_on_failure("The test data file has more entries than the testbench holds");
        end
        t_csr = '0;
        t_dat = '0;
        case (tok)
          "W", "R": rc = $fscanf(fd, "%h %h", t_csr, t_dat) - 2;
          "C": rc = $fscanf(fd, "%h %h %h %h", t_addr, t_type, t_priv, t_allow) - 4;
          "X": rc = $fscanf(fd, "%h %h %h %h %h %h", t_csr, t_dat,
                            t_addr, t_type, t_priv, t_allow) - 6;
          default: stop_on_failure("The test data file has an unknown line type");
        endcase
        if (rc != 0) begin
          stop_on_failure($sformatf("Entry %0d of the test data file is incomplete", num_lines));
        end
        op_mem[num_lines]    = tok;
        csr_mem[num_lines]   = t_csr;
        dat_mem[num_lines]   = t_dat;
        addr_mem[num_lines]  = t_addr;
        type_mem[num_lines]  = t_type;
        priv_mem[num_lines]  = t_priv;
        allow_mem[num_lines] = t_allow;
        num_lines++;
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_bus(input logic we, input logic [`PMP_CSR_AW-1:0] adr,
                           input logic [31:0] dat);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= dat;
  endtask

  task automatic drive_check(input int i);
    chk_valid_i <= 1'b1;
    chk_addr_i  <= addr_mem[i];
    chk_type_i  <= pmp_acc_e'(type_mem[i]);
    chk_priv_i  <= pmp_priv_e'(priv_mem[i]);
  endtask

  // Ack must show up at the first edge after the request and no earlier
  task automatic wait_for_ack();
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!wb_ack_o) begin
      @(negedge clk_i);
      waited++;
    end
    compare_values(32'(waited), 32'd1, "cycles from request to ack");
  endtask

  task automatic release_bus();
    @(posedge clk_i);
    wb_cyc_i    <= 1'b0;
    wb_stb_i    <= 1'b0;
    wb_we_i     <= 1'b0;
    chk_valid_i <= 1'b0;
  endtask

  // Checks go out on consecutive edges and each result is due one cycle later
  task automatic run_checks(input int first, input int count);
    for (int k = 0; k <= count; k++) begin
      @(posedge clk_i);
      if (k < count) begin
        drive_check(first + k);
      end else begin
        chk_valid_i <= 1'b0;
      end
      @(negedge clk_i);
      if (k == 0) begin
        compare_values(32'(chk_valid_o), 32'd0, "valid before the first check of a run");
      end else begin
        compare_values(32'(chk_valid_o), 32'd1,
                       $sformatf("valid of check entry %0d", first + k - 1));
        compare_values(32'(chk_allow_o), 32'(allow_mem[first + k - 1]),
                       $sformatf("allow for address %h", addr_mem[first + k - 1]));
      end
    end
    @(posedge clk_i);
    @(negedge clk_i);
    compare_values(32'(chk_valid_o), 32'd0, "valid after the last check of a run");
  endtask

  initial begin
    int idx;
    int run_len;
    rst_ni      <= 1'b0;
    wb_cyc_i    <= 1'b0;
    wb_stb_i    <= 1'b0;
    wb_we_i     <= 1'b0;
    wb_adr_i    <= '0;
    wb_dat_i    <= '0;
    chk_valid_i <= 1'b0;
    chk_addr_i  <= '0;
    chk_type_i  <= ACC_READ;
    chk_priv_i  <= PRIV_U;
    load_testdata();
    cycle_limit = 8 * num_lines + 100;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    idx = 0;
    while (idx < num_lines) begin
      if (op_mem[idx] == "C") begin
        run_len = 0;
        while ((idx + run_len < num_lines) && (op_mem[idx + run_len] == "C")) begin
          run_len++;
        end
        run_checks(idx, run_len);
        idx += run_len;
      end else begin
        @(posedge clk_i);
        if (op_mem[idx] == "R") begin
          // Reads carry the inverted expected value on the write data lines
          drive_bus(1'b0, csr_mem[idx], ~dat_mem[idx]);
        end else begin
          drive_bus(1'b1, csr_mem[idx], dat_mem[idx]);
        end
        // The check issued with a write sees the old config
        if (op_mem[idx] == "X") begin
          drive_check(idx);
        end
        wait_for_ack();
        if (op_mem[idx] == "R") begin
          compare_values(wb_dat_o, dat_mem[idx], $sformatf("read of CSR %h", csr_mem[idx]));
        end
        if (op_mem[idx] == "X") begin
          compare_values(32'(chk_valid_o), 32'd1, "valid of check beside a write");
          compare_values(32'(chk_allow_o), 32'(allow_mem[idx]),
                         $sformatf("allow for address %h beside a write", addr_mem[idx]));
        end
        release_bus();
        idx++;
      end
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: test/pmp_testdata.txt
# W csr data | R csr expected | C byte_addr type(0 R, 1 W, 2 X) priv(0 U, 3 M) allow
# X csr data byte_addr type priv allow writes a CSR and issues a check on the same edge
R 747 00000000
W 123 DEADBEEF
R 123 00000000
W 3A3 00001B1B
W 3A3 00001102
R 3A3 00001903
W 3A3 00007961
R 3A3 00001901
W 3BF 00001232
W 3A3 18000000
R 3BF 00001233
W 3A3 08000000
R 3BF 00001230
W 3A3 18000000
R 3BF 00001233
W 3B8 00000100
W 3B9 00000200
W 3A2 00008800
W 3A2 00000000
R 3A2 00008800
W 3B9 00000300
R 3B9 00000200
W 3B8 00000150
R 3B8 00000100
W 747 00000004
W 3B8 00000150
R 3B8 00000150
W 3A2 00000000
R 3A2 00000000
W 747 00000000
W 3B0 00000407
W 3B1 00000800
W 3B2 00000C00
W 3B3 0000081F
W 3A0 1C0B001D
C 00001000 0 0 1
C 00001000 1 0 0
C 0000103C 2 0 1
C 00001040 0 0 0
C 00002FFC 1 0 1
C 00002010 2 0 0
C 00003000 0 0 0
C 00003000 0 3 1
W 3B4 00001000
W 3A1 00000018
C 00004000 0 3 1
C 00004000 0 0 0
W 3A1 00000099
C 00004000 2 3 0
C 00004004 0 3 1
X 3A0 1C0B0018 00001000 0 0 1
C 00001000 0 0 0
